// File: Bender.yml
package:
  name: mul_unit

sources:
  - files:
      - verilog/mul_pkg.sv
      - verilog/mul_bus_pkg.sv
      - verilog/mul_dispatch.sv
      - verilog/mul_booth_lane.sv
      - verilog/mul_collect.sv
      - verilog/mul_unit.sv
  - target: test
    files:
      - test/mul_unit_asserts.sv
      - test/mul_unit_tb.sv

// File: compile.f
verilog/mul_pkg.sv
verilog/mul_bus_pkg.sv
verilog/mul_dispatch.sv
verilog/mul_booth_lane.sv
verilog/mul_collect.sv
verilog/mul_unit.sv
test/mul_unit_asserts.sv
test/mul_unit_tb.sv

// File: test/mul_unit_asserts.sv
/*
	Protocol assertions for the multiply unit
	bound into the dispatcher and into every Booth lane
*/
`timescale 1ns/100ps
`default_nettype none

module mul_unit_asserts #(
	parameter int WIDTH       = 1,
	parameter bit LANE_CHECKS = 1'b1
) (
	input wire             clk,
	input wire             rst_n,
	input wire [WIDTH-1:0] start,
	input wire [WIDTH-1:0] busy,
	input wire [WIDTH-1:0] done
);

	import mul_pkg::*;

	int fail_count = 0;

	if (LANE_CHECKS) begin : g_lane
		// start edge plus LANE_CYCLES iteration edges
		done_latency: assert property (@(posedge clk) disable iff (!rst_n)
			start |-> ##(LANE_CYCLES + 1) done)
		else begin
			fail_count++;
			$error("done did not follow start at the fixed lane latency");
		end

		done_idle: assert property (@(posedge clk) disable iff (!rst_n) (done & busy) == '0)
		else begin
			fail_count++;
			$error("lane still busy while done is high");
		end
	end else begin : g_dispatch
		start_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(start))
		else begin
			fail_count++;
			$error("more than one lane start in a cycle");
		end

		// a lane only takes a start while idle
		start_idle: assert property (@(posedge clk) disable iff (!rst_n) (start & busy) == '0)
		else begin
			fail_count++;
			$error("start arrived while the lane was busy");
		end
	end

endmodule

bind mul_dispatch mul_unit_asserts #(
	.WIDTH      (NUM_LANES),
	.LANE_CHECKS(1'b0)
) dispatch_asserts (
	.clk  (clk),
	.rst_n(rst_n),
	.start(lane_start),
	.busy (lane_busy),
	.done ('0)
);

bind mul_booth_lane mul_unit_asserts #(
	.WIDTH      (1),
	.LANE_CHECKS(1'b1)
) lane_asserts (
	.clk  (clk),
	.rst_n(rst_n),
	.start(start),
	.busy (busy),
	.done (done)
);

`default_nettype wire

// File: test/mul_unit_tb.sv
/*
	Testbench for the multi-lane multiply unit
	xorshift traffic checked against a cycle model of latency, drops and flags
*/
`timescale 1ns/100ps
`default_nettype none

module mul_unit_tb;

	import mul_pkg::*;
	import mul_bus_pkg::*;

	localparam int NUM_LANES   = 4;
	localparam int CLK_PERIOD  = 40;
	localparam int LATENCY     = 11;
	localparam int N_SPARSE    = 40;
	localparam int N_CORNER    = 7;
	localparam int N_BURST     = 40;
	localparam int N_MIXED     = 60;
	localparam int N_RESET     = 20;
	localparam int NUM_TESTS   = 6;
	localparam int TOTAL_REQ   = 2 * N_SPARSE + N_CORNER + N_BURST + N_MIXED + N_RESET;
	// up to four clocks per request once gaps are counted
	localparam int WATCHDOG_NS = (4 * TOTAL_REQ + 20 * NUM_TESTS + 50) * CLK_PERIOD;

	typedef struct packed {
		int         due;
		product_t   product;
		mul_flags_t flags;
		logic       is_signed;
		tag_t       tag;
	} expect_t;

	logic        clk;
	logic        rst_n;
	logic        req_valid;
	mul_req_t    req;
	logic        resp_valid;
	mul_resp_t   resp;
	logic        req_drop;
	expect_t     pending[$];
	int          accepted[$];
	int          cyc;
	logic        drop_due;
	logic [31:0] rng;
	tag_t        next_tag;
	int          checks;
	int          errors;
	int          checks_mark;
	int          errors_mark;
	int          test_num;

	mul_unit #(
		.NUM_LANES(NUM_LANES)
	) mul_unit_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.resp_valid(resp_valid),
		.resp      (resp),
		.req_drop  (req_drop)
	);

	// running sum of the lane checker failures
	for (genvar k = 0; k < NUM_LANES; k++) begin : g_fails
		int sum;
		if (k == 0) begin : g_first
			assign sum = mul_unit_inst.g_lane[k].lane_inst.lane_asserts.fail_count;
		end else begin : g_next
			assign sum = g_fails[k-1].sum
				+ mul_unit_inst.g_lane[k].lane_inst.lane_asserts.fail_count;
		end
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// full product of the extended operands, flags by the fit rules
	function automatic expect_t model_result(input mul_req_t r, input int due);
		logic signed [65:0] a;
		logic signed [65:0] b;
		logic signed [65:0] full;
		expect_t            e;
		a = {{34{r.is_signed & r.multiplicand[31]}}, r.multiplicand};
		b = {{34{r.is_signed & r.multiplier[31]}}, r.multiplier};
		full = a * b;
		e.due = due;
		e.product = full[63:0];
		e.is_signed = r.is_signed;
		e.tag = r.tag;
		e.flags.zero = (full == 0);
		e.flags.sign = full[63];
		if (r.is_signed) begin
			e.flags.overflow = (full != {{34{full[31]}}, full[31:0]});
		end else begin
			e.flags.overflow = (full[63:32] != 0);
		end
		return e;
	endfunction

	task automatic check_product(input product_t got, input product_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] resp.product got %h expected %h", got, exp);
		end
	endtask

	task automatic check_flags(input mul_flags_t got, input mul_flags_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] resp.flags got %h expected %h", got, exp);
		end
	endtask

	task automatic check_signed(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] resp.is_signed got %h expected %h", got, exp);
		end
	endtask

	task automatic check_tag(input tag_t got, input tag_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] resp.tag got %h expected %h", got, exp);
		end
	endtask

	// check what the DUT shows at the falling edge, then drive the next input
	task automatic run_cycle(input logic in_reset, input logic valid, input mul_req_t r);
		expect_t e;
		@(negedge clk);
		cyc++;
		if (req_drop !== drop_due) begin
			errors++;
			if (drop_due) begin
				$display("missing req_drop strobe in cycle %0d", cyc);
			end else begin
				$display("unexpected req_drop strobe in cycle %0d", cyc);
			end
		end
		if (resp_valid === 1'b1 && pending.size() > 0 && pending[0].due == cyc) begin
			e = pending.pop_front();
			check_product(resp.product, e.product);
			check_flags(resp.flags, e.flags);
			check_signed(resp.is_signed, e.is_signed);
			check_tag(resp.tag, e.tag);
		end else if (resp_valid !== 1'b0) begin
			errors++;
			$display("unexpected response strobe in cycle %0d", cyc);
		end else if (pending.size() > 0 && pending[0].due == cyc) begin
			errors++;
			$display("missing response for tag %h in cycle %0d", pending[0].tag, cyc);
			void'(pending.pop_front());
		end
		drop_due = 1'b0;
		if (in_reset) begin
			rst_n     <= 1'b0;
			req_valid <= 1'b0;
			pending.delete();
			accepted.delete();
		end else begin
			rst_n     <= 1'b1;
			req_valid <= valid;
			req       <= r;
			if (valid) begin
				// lanes taken by requests of the last LANE_CYCLES clocks
				while (accepted.size() > 0 && accepted[0] < cyc - LANE_CYCLES) begin
					void'(accepted.pop_front());
				end
				if (accepted.size() < NUM_LANES) begin
					accepted.push_back(cyc);
					pending.push_back(model_result(r, cyc + LATENCY + 1));
				end else begin
					drop_due = 1'b1;
				end
			end
		end
	endtask

	task automatic idle(input int n);
		repeat (n) run_cycle(1'b0, 1'b0, '0);
	endtask

	task automatic send(input logic is_signed, input operand_t a, input operand_t b);
		mul_req_t r;
		r = '{multiplicand: a, multiplier: b, is_signed: is_signed, tag: next_tag};
		next_tag++;
		run_cycle(1'b0, 1'b1, r);
	endtask

	task automatic send_sparse(input logic is_signed, input operand_t a, input operand_t b);
		send(is_signed, a, b);
		idle(2);
	endtask

	// drain outstanding responses, then print the test line
	task automatic end_test(input string name);
		int n;
		n = 0;
		while (pending.size() > 0 && n < 20) begin
			idle(1);
			n++;
		end
		idle(1);
		test_num++;
		$display("test %0d %s: %0d checks, %0d errors", test_num, name,
			checks - checks_mark, errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		logic [31:0] pick;
		int          fails;
		rst_n       = 1'b0;
		req_valid   = 1'b0;
		req         = '0;
		rng         = 32'hc37d70cd;
		next_tag    = '0;
		cyc         = 0;
		drop_due    = 1'b0;
		checks      = 0;
		errors      = 0;
		checks_mark = 0;
		errors_mark = 0;
		test_num    = 0;
		// first rising edge already sees reset, this adds the second
		run_cycle(1'b1, 1'b0, '0);

		repeat (N_SPARSE) send_sparse(1'b0, next_random(), next_random());
		end_test("unsigned sparse");

		repeat (N_SPARSE) send_sparse(1'b1, next_random(), next_random());
		end_test("signed sparse");

		send_sparse(1'b0, '0, next_random());
		send_sparse(1'b1, next_random(), '0);
		send_sparse(1'b1, '0, 32'h8000_0000);
		send_sparse(1'b0, '1, '1);
		send_sparse(1'b1, '1, '1);
		send_sparse(1'b1, 32'h8000_0000, 32'h8000_0000);
		send_sparse(1'b0, 32'h8000_0000, 32'h8000_0000);
		end_test("corner operands");

		repeat (N_BURST) begin
			pick = next_random();
			send(pick[0], next_random(), next_random());
		end
		end_test("back-to-back drops");

		repeat (N_MIXED) begin
			pick = next_random();
			send(pick[0], next_random(), next_random());
			idle(int'(pick[2:1]));
		end
		end_test("mixed gaps");

		repeat (8) send(1'b1, next_random(), next_random());
		repeat (2) run_cycle(1'b1, 1'b0, '0);
		// nothing from before reset may come out
		idle(16);
		repeat (N_RESET - 8) send_sparse(1'b0, next_random(), next_random());
		end_test("reset mid-stream");

		fails = mul_unit_inst.dispatch_inst.dispatch_asserts.fail_count
			+ g_fails[NUM_LANES-1].sum;
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			test_num, checks, errors, fails);
		if (errors == 0 && fails == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/mul_booth_lane.sv
/*
	Iterative radix-4 Booth multiplier lane
	retires two digits per clock, one product every LANE_CYCLES clocks
*/
`timescale 1ns/100ps
`default_nettype none

module mul_booth_lane (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    start,
	input  wire mul_bus_pkg::mul_req_t req,
	output logic                   busy,
	output logic                   done,
	output mul_bus_pkg::mul_resp_t resp
);

	import mul_pkg::*;
	import mul_bus_pkg::*;

	localparam int MCAND_W = OPERAND_W + 1;
	localparam int MPLR_W  = 2 * BOOTH_DIGITS;
	localparam int CNT_W   = $clog2(LANE_CYCLES);

	logic               running;
	logic [CNT_W-1:0]   step;
	logic               last;
	logic [MCAND_W-1:0] mcand;
	logic [MPLR_W-1:0]  mplr;
	logic               mplr_prev;
	logic [ACC_W-1:0]   acc;
	logic               is_signed_q;
	tag_t               tag_q;
	booth_digit_t       dig_lo;
	booth_digit_t       dig_hi;
	logic [ACC_W-1:0]   pp_lo;
	logic [ACC_W-1:0]   pp_hi;
	logic               mcand_ext;
	logic               mplr_ext;

	// one overlapping triple {b[i+1], b[i], b[i-1]} to a signed digit
	function automatic booth_digit_t booth_encode(input logic [2:0] triple);
		booth_digit_t d;
		case (triple)
			3'b001, 3'b010: d = {1'b0, MAG_ONE};
			3'b011:         d = {1'b0, MAG_TWO};
			3'b100:         d = {1'b1, MAG_TWO};
			3'b101, 3'b110: d = {1'b1, MAG_ONE};
			default:        d = {1'b0, MAG_ZERO};
		endcase
		return d;
	endfunction

	// digit times multiplicand, sign extended to the accumulator width
	function automatic logic [ACC_W-1:0] booth_partial(input booth_digit_t d,
			input logic [MCAND_W-1:0] a);
		logic [ACC_W-1:0] ext;
		logic [ACC_W-1:0] mag;
		ext = {{(ACC_W-MCAND_W){a[MCAND_W-1]}}, a};
		case (d.mag)
			MAG_ONE: mag = ext;
			MAG_TWO: mag = ext << 1;
			default: mag = '0;
		endcase
		if (d.neg) begin
			return -mag;
		end
		return mag;
	endfunction

	assign dig_lo = booth_encode({mplr[1:0], mplr_prev});
	assign dig_hi = booth_encode(mplr[3:1]);

	// digit position is four bits per step, the upper digit two more
	assign pp_lo = booth_partial(dig_lo, mcand) << {step, 2'b00};
	assign pp_hi = booth_partial(dig_hi, mcand) << ({step, 2'b00} + 6'd2);

	assign last = running && (step == CNT_W'(LANE_CYCLES - 1));

	// free for a new start once the final step is under way
	assign busy = running && !last;

	assign mcand_ext = req.is_signed & req.multiplicand[OPERAND_W-1];
	assign mplr_ext  = req.is_signed & req.multiplier[OPERAND_W-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running <= 1'b0;
			step    <= '0;
			done    <= 1'b0;
		end else begin
			done <= last;
			if (start) begin
				running <= 1'b1;
				step    <= '0;
			end else if (last) begin
				running <= 1'b0;
			end else if (running) begin
				step <= step + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand       <= {mcand_ext, req.multiplicand};
			mplr        <= {{(MPLR_W-OPERAND_W){mplr_ext}}, req.multiplier};
			mplr_prev   <= 1'b0;
			acc         <= '0;
			is_signed_q <= req.is_signed;
			tag_q       <= req.tag;
		end else if (running) begin
			acc       <= acc + pp_lo + pp_hi;
			mplr      <= mplr >> 4;
			mplr_prev <= mplr[3];
		end
	end

	// guard bits above the product are dropped
	assign resp.product   = acc[2*OPERAND_W-1:0];
	assign resp.flags     = '0;
	assign resp.is_signed = is_signed_q;
	assign resp.tag       = tag_q;

endmodule

`default_nettype wire

// File: verilog/mul_bus_pkg.sv
/*
	Multiply unit transactions
	request and response structs exchanged with the execute stage
*/
`default_nettype none

package mul_bus_pkg;

	import mul_pkg::*;

	localparam int TAG_W = 8;

	// request identifier, returned unchanged
	typedef logic [TAG_W-1:0] tag_t;

	typedef struct packed {
		operand_t multiplicand;
		operand_t multiplier;
		logic     is_signed;
		tag_t     tag;
	} mul_req_t;

	// flags stay clear until the collector fills them in
	typedef struct packed {
		product_t   product;
		mul_flags_t flags;
		logic       is_signed;
		tag_t       tag;
	} mul_resp_t;

endpackage

`default_nettype wire

// File: verilog/mul_collect.sv
/*
	Multiply result collector
	picks the finishing lane, derives the flags and registers the response
*/
`timescale 1ns/100ps
`default_nettype none

module mul_collect #(
	parameter int NUM_LANES = 4
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire [NUM_LANES-1:0]    lane_done,
	input  wire mul_bus_pkg::mul_resp_t lane_resp [NUM_LANES],
	output logic                   resp_valid,
	output mul_bus_pkg::mul_resp_t resp
);

	import mul_pkg::*;
	import mul_bus_pkg::*;

	mul_resp_t          sel;
	mul_flags_t         flags;
	logic [OPERAND_W:0] upper;

	// at most one lane finishes per cycle, so OR-ing the masked responses is safe
	always_comb begin
		sel = '0;
		for (int k = 0; k < NUM_LANES; k++) begin
			sel = sel | (lane_resp[k] & {$bits(mul_resp_t){lane_done[k]}});
		end
	end

	// top 33 bits, the sign of the low word included
	assign upper = sel.product[2*OPERAND_W-1 -: OPERAND_W+1];

	assign flags.zero = (sel.product == '0);
	assign flags.sign = sel.product[2*OPERAND_W-1];

	// signed fits when the top 33 bits all match the sign
	assign flags.overflow = sel.is_signed ? !((&upper) || (upper == '0))
	                                      : (upper[OPERAND_W:1] != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= |lane_done;
		end
	end

	always_ff @(posedge clk) begin
		if (|lane_done) begin
			resp <= '{product:   sel.product,
			          flags:     flags,
			          is_signed: sel.is_signed,
			          tag:       sel.tag};
		end
	end

endmodule

`default_nettype wire

// File: verilog/mul_dispatch.sv
/*
	Multiply dispatcher
	hands each request to the lowest idle lane, or flags a drop
*/
`timescale 1ns/100ps
`default_nettype none

module mul_dispatch #(
	parameter int NUM_LANES = 4
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   req_valid,
	input  wire mul_bus_pkg::mul_req_t req,
	input  wire [NUM_LANES-1:0]   lane_busy,
	output logic [NUM_LANES-1:0]  lane_start,
	output mul_bus_pkg::mul_req_t lane_req,
	output logic                  req_drop
);

	logic [NUM_LANES-1:0] idle;
	logic [NUM_LANES-1:0] pick;
	logic                 none_idle;

	// a lane started last cycle has not raised busy yet
	assign idle = ~lane_busy & ~lane_start;

	// lowest set bit of the idle mask
	assign pick = idle & (-idle);

	assign none_idle = (idle == '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lane_start <= '0;
			req_drop   <= 1'b0;
		end else begin
			if (req_valid) begin
				lane_start <= pick;
			end else begin
				lane_start <= '0;
			end
			req_drop <= req_valid && none_idle;
		end
	end

	// request payload shared by all lanes
	always_ff @(posedge clk) begin
		if (req_valid) begin
			lane_req <= req;
		end
	end

endmodule

`default_nettype wire

// File: verilog/mul_pkg.sv
/*
	Multiply arithmetic types
	operand and product widths, radix-4 Booth digit encoding and result flags
*/
`default_nettype none

package mul_pkg;

	// operand and product widths
	localparam int OPERAND_W = 32;

	typedef logic [OPERAND_W-1:0]   operand_t;
	typedef logic [2*OPERAND_W-1:0] product_t;

	// accumulator carries two guard bits above the product
	localparam int ACC_W = 2 * OPERAND_W + 2;

	// multiplier extended to 36 bits covers the 33-bit signed view
	localparam int BOOTH_DIGITS = 18;

	// two digits retired per clock
	localparam int LANE_CYCLES = BOOTH_DIGITS / 2;

	// digit magnitude in multiples of the multiplicand
	localparam logic [1:0] MAG_ZERO = 2'd0;
	localparam logic [1:0] MAG_ONE  = 2'd1;
	localparam logic [1:0] MAG_TWO  = 2'd2;

	// encoded booth digit, neg set means subtract
	typedef struct packed {
		logic       neg;
		logic [1:0] mag;
	} booth_digit_t;

	// result flags
	typedef struct packed {
		logic zero;
		logic sign;
		logic overflow;
	} mul_flags_t;

endpackage

`default_nettype wire

// File: verilog/mul_unit.sv
/*
	Multi-lane multiply unit
	dispatcher, array of Booth lanes and result collector
*/
`timescale 1ns/100ps
`default_nettype none

module mul_unit #(
	parameter int NUM_LANES = 4
) (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         req_valid,
	input  wire mul_bus_pkg::mul_req_t  req,
	output wire                         resp_valid,
	output wire mul_bus_pkg::mul_resp_t resp,
	output wire                         req_drop
);

	import mul_bus_pkg::*;

	wire [NUM_LANES-1:0] lane_busy;
	wire [NUM_LANES-1:0] lane_start;
	wire [NUM_LANES-1:0] lane_done;
	wire mul_req_t       lane_req;
	wire mul_resp_t      lane_resp [NUM_LANES];

	mul_dispatch #(
		.NUM_LANES(NUM_LANES)
	) dispatch_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.lane_busy (lane_busy),
		.lane_start(lane_start),
		.lane_req  (lane_req),
		.req_drop  (req_drop)
	);

	// identical lanes, all fed from the shared request register
	for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
		mul_booth_lane lane_inst (
			.clk  (clk),
			.rst_n(rst_n),
			.start(lane_start[k]),
			.req  (lane_req),
			.busy (lane_busy[k]),
			.done (lane_done[k]),
			.resp (lane_resp[k])
		);
	end

	mul_collect #(
		.NUM_LANES(NUM_LANES)
	) collect_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.lane_done (lane_done),
		.lane_resp (lane_resp),
		.resp_valid(resp_valid),
		.resp      (resp)
	);

endmodule

`default_nettype wire
